// ==== hw/btbPkg.sv ====
/*
 * BTB sizes, index/tag/bank field helpers,
 * the shared entry and update structs, and the clearing FSM state type
 */
package btbPkg;

    localparam int fetchWidth = 2;
    localparam int issueWidth = 2;
    localparam int entryNum = 64;
    localparam int bankNum = 4;
    localparam int queueDepth = 4;
    localparam int insnBytes = 4;

    localparam int insnShift = $clog2(insnBytes);
    localparam int indexBits = $clog2(entryNum);
    localparam int bankBits = $clog2(bankNum);
    localparam int rowNum = entryNum / bankNum;
    localparam int tagBits = 8;
    localparam int targetLowBits = 16;

    typedef logic [31:0] pcT;
    typedef logic [indexBits-1:0] indexT;
    typedef logic [bankBits-1:0] bankT;
    typedef logic [indexBits-bankBits-1:0] rowT;
    typedef logic [tagBits-1:0] tagT;
    typedef logic [targetLowBits-1:0] targetLowT;
    typedef logic [$clog2(queueDepth)-1:0] queuePtrT;
    typedef logic [$clog2(queueDepth):0] queueCountT;

    // Compressed entry, upper target half comes from the fetch PC
    typedef struct packed {
        logic valid;
        logic isCondBr;
        tagT tag;
        targetLowT targetLow;
    } btbEntryT;

    typedef struct packed {
        logic valid;
        logic taken;
        logic isCondBr;
        pcT brAddr;
        pcT nextAddr;
    } brResultT;

    typedef struct packed {
        logic hit;
        logic isCondBr;
        pcT target;
    } lookupT;

    typedef struct packed {
        indexT index;
        btbEntryT entry;
    } pendingWriteT;

    typedef enum logic {
        clearing,
        running
    } initStateT;

    function automatic indexT toIndex(input pcT pc);
        return pc[indexBits+insnShift-1:insnShift];
    endfunction

    function automatic tagT toTag(input pcT pc);
        return pc[tagBits+indexBits+insnShift-1:indexBits+insnShift];
    endfunction

    // Bank is taken from the low index bits
    function automatic bankT toBank(input indexT index);
        return index[bankBits-1:0];
    endfunction

    function automatic rowT toRow(input indexT index);
        return index[indexBits-1:bankBits];
    endfunction

    function automatic pcT rebuildTarget(input pcT fetchPc, input targetLowT targetLow);
        return {fetchPc[31:targetLowBits], targetLow};
    endfunction

endpackage

// ==== hw/multiBankRam.sv ====
/*
 * Banked storage for BTB entries
 * One write per bank per cycle, picked from the update ports
 * Registered read for every fetch slot
 */
`timescale 1ns/10ps

module multiBankRam import btbPkg::*; (
    input  logic                         clk,
    input  logic     [issueWidth-1:0]    writeEn,
    input  indexT    [issueWidth-1:0]    writeIndex,
    input  btbEntryT [issueWidth-1:0]    writeData,
    input  indexT    [fetchWidth-1:0]    readIndex,
    output btbEntryT [fetchWidth-1:0]    readData
);

    btbEntryT mem [bankNum][rowNum];

    logic     [bankNum-1:0] bankWe;
    rowT      [bankNum-1:0] bankRow;
    btbEntryT [bankNum-1:0] bankData;

    // Route each write port to the bank its index selects
    always_comb begin
        bankWe = '0;
        bankRow = '0;
        bankData = '0;
        for (int b = 0; b < bankNum; b++) begin
            for (int p = 0; p < issueWidth; p++) begin
                if (writeEn[p] && !bankWe[b] && toBank(writeIndex[p]) == bankT'(b)) begin
                    bankWe[b] = 1'b1;
                    bankRow[b] = toRow(writeIndex[p]);
                    bankData[b] = writeData[p];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < bankNum; b++) begin
            if (bankWe[b]) begin
                mem[b][bankRow[b]] <= bankData[b];
            end
        end
        // Read returns the old value when written on the same edge
        for (int s = 0; s < fetchWidth; s++) begin
            readData[s] <= mem[toBank(readIndex[s])][toRow(readIndex[s])];
        end
    end

endmodule

// ==== hw/conflictQueue.sv ====
/*
 * Circular FIFO holding BTB writes deferred by bank conflicts
 * Wrapping head/tail pointers with an occupancy count
 */
`timescale 1ns/10ps

module conflictQueue import btbPkg::*; (
    input  logic         clk,
    input  logic         rstN,
    input  logic         push,
    input  pendingWriteT pushData,
    input  logic         pop,
    output pendingWriteT headData,
    output logic         empty,
    output logic         full
);

    pendingWriteT mem [queueDepth];

    queuePtrT   headPtr;
    queuePtrT   tailPtr;
    queueCountT count;
    logic       doPush;
    logic       doPop;

    assign doPush = push && !full;
    assign doPop = pop && !empty;

    assign empty = (count == '0);
    assign full = (count == queueCountT'(queueDepth));
    assign headData = mem[headPtr];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                tailPtr <= (tailPtr == queuePtrT'(queueDepth - 1)) ? '0 : tailPtr + 1'b1;
            end
            if (doPop) begin
                headPtr <= (headPtr == queuePtrT'(queueDepth - 1)) ? '0 : headPtr + 1'b1;
            end
            // Simultaneous push and pop keep the count
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[tailPtr] <= pushData;
        end
    end

endmodule

// ==== hw/branchTargetBuffer.sv ====
/*
 * BTB core: slot lookup, tag compare and target rebuild,
 * update arbitration with bank conflict deferral to the queue,
 * and the post-reset clearing FSM
 */
`timescale 1ns/10ps

module branchTargetBuffer import btbPkg::*; (
    input  logic                         clk,
    input  logic                         rstN,
    input  pcT                           fetchPc,
    input  brResultT [issueWidth-1:0]    brResult,
    output lookupT   [fetchWidth-1:0]    lookup,
    output logic                         initBusy,
    output logic     [issueWidth-1:0]    writeEn,
    output indexT    [issueWidth-1:0]    writeIndex,
    output btbEntryT [issueWidth-1:0]    writeData,
    output indexT    [fetchWidth-1:0]    readIndex,
    input  btbEntryT [fetchWidth-1:0]    readData,
    output logic                         push,
    output pendingWriteT                 pushData,
    output logic                         pop,
    input  pendingWriteT                 headData,
    input  logic                         empty,
    input  logic                         full
);

    initStateT state;
    indexT     clearIdx;
    logic      probeOk;

    pcT [fetchWidth-1:0] slotPc;
    pcT [fetchWidth-1:0] slotPcReg;

    logic     [issueWidth-1:0] req;
    indexT    [issueWidth-1:0] reqIndex;
    btbEntryT [issueWidth-1:0] reqEntry;
    logic                      deferred;
    logic                      headClash;
    logic                      drained;

    assign initBusy = (state == clearing);

    // Sequential slot addresses, probed in the RAM this cycle
    always_comb begin
        for (int s = 0; s < fetchWidth; s++) begin
            slotPc[s] = fetchPc + pcT'(s * insnBytes);
            readIndex[s] = toIndex(slotPc[s]);
        end
    end

    // Hit check one cycle later, against the registered slot PC
    always_comb begin
        for (int s = 0; s < fetchWidth; s++) begin
            lookup[s].hit = probeOk && readData[s].valid
                            && (readData[s].tag == toTag(slotPcReg[s]));
            lookup[s].isCondBr = readData[s].isCondBr;
            lookup[s].target = rebuildTarget(slotPcReg[s], readData[s].targetLow);
        end
    end

    // Only taken branches are learned
    always_comb begin
        for (int p = 0; p < issueWidth; p++) begin
            req[p] = brResult[p].valid && brResult[p].taken;
            reqIndex[p] = toIndex(brResult[p].brAddr);
            reqEntry[p].valid = 1'b1;
            reqEntry[p].isCondBr = brResult[p].isCondBr;
            reqEntry[p].tag = toTag(brResult[p].brAddr);
            reqEntry[p].targetLow = brResult[p].nextAddr[targetLowBits-1:0];
        end
    end

    always_comb begin
        deferred = 1'b0;
        headClash = 1'b0;
        drained = 1'b0;
        push = 1'b0;
        pushData = '0;
        pop = 1'b0;
        writeEn = req;
        writeIndex = reqIndex;
        writeData = reqEntry;

        // Higher port yields to a lower port on the same bank
        for (int i = 1; i < issueWidth; i++) begin
            for (int j = 0; j < i; j++) begin
                if (writeEn[i] && writeEn[j]
                    && toBank(writeIndex[i]) == toBank(writeIndex[j])) begin
                    writeEn[i] = 1'b0;
                    // One push per cycle, dropped when the queue is full
                    if (!deferred && !full) begin
                        push = 1'b1;
                        pushData.index = reqIndex[i];
                        pushData.entry = reqEntry[i];
                    end
                    deferred = 1'b1;
                end
            end
        end

        // Queue head takes the first idle port if its bank is free
        for (int j = 0; j < issueWidth; j++) begin
            if (writeEn[j] && toBank(writeIndex[j]) == toBank(headData.index)) begin
                headClash = 1'b1;
            end
        end
        if (!empty && !headClash) begin
            for (int i = 0; i < issueWidth; i++) begin
                if (!drained && !writeEn[i]) begin
                    writeEn[i] = 1'b1;
                    writeIndex[i] = headData.index;
                    writeData[i] = headData.entry;
                    pop = 1'b1;
                    drained = 1'b1;
                end
            end
        end

        // Clearing owns port 0 and blocks everything else
        if (state == clearing) begin
            writeEn = '0;
            writeEn[0] = 1'b1;
            for (int p = 0; p < issueWidth; p++) begin
                writeIndex[p] = clearIdx;
            end
            writeData = '0;
            push = 1'b0;
            pop = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= clearing;
            clearIdx <= '0;
            probeOk <= 1'b0;
        end else begin
            probeOk <= (state == running);
            if (state == clearing) begin
                clearIdx <= clearIdx + 1'b1;
                if (clearIdx == indexT'(entryNum - 1)) begin
                    state <= running;
                end
            end
        end
    end

    // Aligns slot PCs with the RAM read latency
    always_ff @(posedge clk) begin
        slotPcReg <= slotPc;
    end

endmodule

// ==== hw/btbTop.sv ====
/*
 * BTB top level
 * Connects the core to entry storage and the conflict queue
 */
`timescale 1ns/10ps

module btbTop import btbPkg::*; (
    input  logic                         clk,
    input  logic                         rstN,
    input  pcT                           fetchPc,
    input  brResultT [issueWidth-1:0]    brResult,
    output lookupT   [fetchWidth-1:0]    lookup,
    output logic                         initBusy
);

    logic     [issueWidth-1:0] writeEn;
    indexT    [issueWidth-1:0] writeIndex;
    btbEntryT [issueWidth-1:0] writeData;
    indexT    [fetchWidth-1:0] readIndex;
    btbEntryT [fetchWidth-1:0] readData;

    logic         push;
    pendingWriteT pushData;
    logic         pop;
    pendingWriteT headData;
    logic         empty;
    logic         full;

    branchTargetBuffer core_i (
        .clk        (clk),
        .rstN       (rstN),
        .fetchPc    (fetchPc),
        .brResult   (brResult),
        .lookup     (lookup),
        .initBusy   (initBusy),
        .writeEn    (writeEn),
        .writeIndex (writeIndex),
        .writeData  (writeData),
        .readIndex  (readIndex),
        .readData   (readData),
        .push       (push),
        .pushData   (pushData),
        .pop        (pop),
        .headData   (headData),
        .empty      (empty),
        .full       (full)
    );

    multiBankRam ram_i (
        .clk        (clk),
        .writeEn    (writeEn),
        .writeIndex (writeIndex),
        .writeData  (writeData),
        .readIndex  (readIndex),
        .readData   (readData)
    );

    conflictQueue queue_i (
        .clk        (clk),
        .rstN       (rstN),
        .push       (push),
        .pushData   (pushData),
        .pop        (pop),
        .headData   (headData),
        .empty      (empty),
        .full       (full)
    );

endmodule

// ==== bench/clockGen.sv ====
/*
 * Free-running testbench clock, 20 ns period
 */
`timescale 1ns/10ps

module clockGen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

endmodule

// ==== bench/btbTb.sv ====
/*
 * BTB testbench with directed tests, a reference model of the entries,
 * value checker, xorshift stimulus and reset control
 */
`timescale 1ns/10ps

module btbTb import btbPkg::*; ();

    logic                      clk;
    logic                      rstN;
    pcT                        fetchPc;
    brResultT [issueWidth-1:0] brResult;
    lookupT   [fetchWidth-1:0] lookup;
    logic                      initBusy;

    // Reference model with one record per BTB index
    logic        refValid [entryNum];
    logic        refCond [entryNum];
    logic [7:0]  refTag [entryNum];
    logic [15:0] refLow [entryNum];
    logic [31:0] rngState;

    clockGen clockGen_i (.clk(clk));

    btbTop dut_i (
        .clk      (clk),
        .rstN     (rstN),
        .fetchPc  (fetchPc),
        .brResult (brResult),
        .lookup   (lookup),
        .initBusy (initBusy)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic brResultT makeResult(input logic valid, input logic taken,
                                            input logic cond, input pcT addr, input pcT next);
        brResultT r;
        r.valid = valid;
        r.taken = taken;
        r.isCondBr = cond;
        r.brAddr = addr;
        r.nextAddr = next;
        return r;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            failRun($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    // Index from PC bits 7..2 and tag from PC bits 15..8
    task automatic learn(input pcT addr, input pcT next, input logic cond);
        refValid[addr[7:2]] = 1'b1;
        refCond[addr[7:2]] = cond;
        refTag[addr[7:2]] = addr[15:8];
        refLow[addr[7:2]] = next[15:0];
    endtask

    task automatic sendUpdates(input brResultT r0, input brResultT r1);
        @(posedge clk);
        brResult[0] <= r0;
        brResult[1] <= r1;
    endtask

    // Lookup results are valid one cycle after fetchPc and sampled mid-cycle
    task automatic probe(input pcT pc);
        @(posedge clk);
        fetchPc <= pc;
        brResult <= '0;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic probeCheck(input pcT pc);
        pcT   spc;
        logic expHit;
        probe(pc);
        for (int s = 0; s < fetchWidth; s++) begin
            spc = pc + pcT'(s * insnBytes);
            expHit = refValid[spc[7:2]] && (refTag[spc[7:2]] == spc[15:8]);
            checkEq($sformatf("lookup[%0d].hit", s), 32'(lookup[s].hit), 32'(expHit));
            if (expHit) begin
                checkEq($sformatf("lookup[%0d].isCondBr", s), 32'(lookup[s].isCondBr),
                        32'(refCond[spc[7:2]]));
                checkEq($sformatf("lookup[%0d].target", s), lookup[s].target,
                        {spc[31:16], refLow[spc[7:2]]});
            end
        end
    endtask

    task automatic testAfterReset();
        probeCheck(32'h0000_0000);
        probeCheck(32'h0000_1000);
        probeCheck(32'hdead_beec);
    endtask

    task automatic testSingleUpdate();
        sendUpdates(makeResult(1'b1, 1'b1, 1'b1, 32'h0001_2340, 32'h0001_8888), '0);
        learn(32'h0001_2340, 32'h0001_8888, 1'b1);
        probeCheck(32'h0001_2340);
        // Not-taken on port 1 and an invalid taken result on port 0 are not learned
        sendUpdates(makeResult(1'b0, 1'b1, 1'b0, 32'h0000_0500, 32'h0000_0600),
                    makeResult(1'b1, 1'b0, 1'b1, 32'h0000_0480, 32'h0000_0700));
        probeCheck(32'h0000_0480);
        probeCheck(32'h0000_0500);
    endtask

    task automatic testDualBanks();
        sendUpdates(makeResult(1'b1, 1'b1, 1'b0, 32'h0004_0010, 32'h0004_1234),
                    makeResult(1'b1, 1'b1, 1'b1, 32'h0004_0014, 32'h0004_abcd));
        learn(32'h0004_0010, 32'h0004_1234, 1'b0);
        learn(32'h0004_0014, 32'h0004_abcd, 1'b1);
        probeCheck(32'h0004_0010);
    endtask

    task automatic testSameBank();
        logic hitA;
        logic hitB;
        int   tries;
        // Index 8 and index 12 both land in bank 0
        sendUpdates(makeResult(1'b1, 1'b1, 1'b1, 32'h0003_0020, 32'h0003_4000),
                    makeResult(1'b1, 1'b1, 1'b0, 32'h0007_0030, 32'h0007_5550));
        learn(32'h0003_0020, 32'h0003_4000, 1'b1);
        learn(32'h0007_0030, 32'h0007_5550, 1'b0);
        hitA = 1'b0;
        hitB = 1'b0;
        tries = 0;
        while (!(hitA && hitB) && tries < 20) begin
            probe(32'h0003_0020);
            hitA = lookup[0].hit;
            probe(32'h0007_0030);
            hitB = lookup[0].hit;
            tries++;
        end
        if (!(hitA && hitB)) begin
            failRun("Timeout: deferred same-bank update never became visible");
        end
        probeCheck(32'h0003_0020);
        probeCheck(32'h0007_0030);
    endtask

    task automatic testAlias();
        sendUpdates(makeResult(1'b1, 1'b1, 1'b0, 32'h0000_1244, 32'h0000_2468), '0);
        learn(32'h0000_1244, 32'h0000_2468, 1'b0);
        probeCheck(32'h0000_1244);
        probeCheck(32'h0000_1344);
        sendUpdates(makeResult(1'b1, 1'b1, 1'b1, 32'h0000_1344, 32'h0000_9bd0), '0);
        learn(32'h0000_1344, 32'h0000_9bd0, 1'b1);
        probeCheck(32'h0000_1344);
        probeCheck(32'h0000_1244);
    endtask

    task automatic testRandom();
        pcT addr;
        pcT next;
        pcT pc;
        for (int i = 0; i < 200; i++) begin
            rngState = xorshift(rngState);
            addr = rngState;
            rngState = xorshift(rngState);
            next = rngState;
            sendUpdates(makeResult(1'b1, 1'b1, next[31], addr, next), '0);
            learn(addr, next, next[31]);
            rngState = xorshift(rngState);
            case (rngState[1:0])
                2'd2: pc = addr - pcT'(insnBytes);
                2'd3: pc = xorshift(rngState);
                default: pc = addr;
            endcase
            probeCheck(pc);
        end
    endtask

    initial begin
        int cnt;
        rstN = 1'b0;
        fetchPc = '0;
        brResult = '0;
        rngState = 32'hb71d;
        for (int i = 0; i < entryNum; i++) begin
            refValid[i] = 1'b0;
        end
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkEq("initBusy", 32'(initBusy), 32'd1);
        checkEq("lookup[0].hit", 32'(lookup[0].hit), 32'd0);
        checkEq("lookup[1].hit", 32'(lookup[1].hit), 32'd0);
        cnt = 0;
        while (initBusy && cnt < entryNum + 20) begin
            @(negedge clk);
            cnt++;
        end
        if (initBusy) begin
            failRun("Timeout: initBusy stayed high after the clearing sequence");
        end
        testAfterReset();
        testSingleUpdate();
        testDualBanks();
        testSameBank();
        testAlias();
        testRandom();
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== btbTop.f ====
hw/btbPkg.sv
hw/multiBankRam.sv
hw/conflictQueue.sv
hw/branchTargetBuffer.sv
hw/btbTop.sv
bench/clockGen.sv
bench/btbTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build and run the BTB testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module btbTb -f btbTop.f -o simv

out=$(./obj_dir/simv 2>&1 || true)
echo "$out"

if grep -q "TEST OK" <<< "$out"; then
    exit 0
else
    exit 1
fi
